/* test/fetch_patterns.txt */
// columns: op _ hold _ count _ f0 _ f1 _ f2 _ f3, all hex
// 01 fill f1 beats from beat f0 with seed f2, 02 trap vector f0, 03 random ready from count to f0
// 1x redirect after count outputs and hold cycles, x bits 0 jal 1 branch 2 jalr 3 trap
//    f0 ex_pc, f1 imm, f2 rs1, f3 alu result; 04 expect f1 outputs from pc f0
01_00_0000_0000000000000000_0000000000000080_0000000000100013_0000000000000000
01_00_0000_0000000000000080_0000000000000080_0000000000a00093_0000000000000000
02_00_0000_0000000080000603_0000000000000000_0000000000000000_0000000000000000
03_00_0016_0000000000000028_0000000000000000_0000000000000000_0000000000000000
// straight line from the reset vector
04_00_0000_0000000080000000_0000000000000006_0000000000000000_0000000000000000
11_00_0006_0000000080000014_000000000000003c_0000000000000000_0000000000000000
04_00_0000_0000000080000050_0000000000000003_0000000000000000_0000000000000000
// branch with zero alu result, then one with nonzero result
12_00_0009_0000000080000058_0000000000000100_0000000000000000_0000000000000000
04_00_0000_0000000080000158_0000000000000004_0000000000000000_0000000000000000
12_00_000b_0000000080000160_0000000000000200_0000000000000000_0000000000000005
// jal and jalr together
15_00_000d_0000000080000168_0000000000000020_0000000080000400_0000000000000000
04_00_0000_0000000080000188_0000000000000002_0000000000000000_0000000000000000
// jalr with odd sum
14_00_000f_0000000000000000_0000000000000044_0000000080000401_0000000000000000
04_00_0000_0000000080000444_0000000000000003_0000000000000000_0000000000000000
// trap to the written vector
18_00_0012_0000000080000450_0000000000000008_0000000000000000_0000000000000000
04_00_0000_0000000080000600_000000000000000a_0000000000000000_0000000000000000
// redirect after the queue has filled
12_28_001c_0000000080000620_fffffffffffffa10_0000000000000000_0000000000000000
04_00_0000_0000000080000030_000000000000000c_0000000000000000_0000000000000000

/* list.f */
rtl/rv_fetch_pkg.sv
rtl/rd_bus_pkg.sv
rtl/fetch_redirect.sv
rtl/trap_vector_regs.sv
rtl/fetch_unit.sv
rtl/fetch_queue.sv
rtl/imem_ram.sv
rtl/fetch_top.sv
test/tb_fetch.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module tb_fetch --Mdir obj_dir -o tb_fetch

./obj_dir/tb_fetch 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* test/tb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;
    import rv_fetch_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int N_REC       = 64;
    // longest gap between accepted outputs, covers the redirect hold
    localparam int STALL_LIMIT = 200;

    logic            clk;
    logic            reset_i;
    logic            br_taken_i;
    logic            jal_i;
    logic            jalr_i;
    logic            trap_i;
    xlen_t           alu_res_i;
    xlen_t           ex_pc_i;
    xlen_t           imm_i;
    xlen_t           rs1_i;
    logic            tvec_we_i;
    xlen_t           tvec_wdata_i;
    logic            load_we_i;
    logic [7:0]      load_addr_i;
    logic [63:0]     load_data_i;
    logic            out_valid_o;
    logic            out_ready_i;
    xlen_t           out_pc_o;
    inst_t           out_inst_o;
    redirect_cause_t redir_cause;

    // op, hold, count, then four 64-bit fields
    logic [287:0] pat [N_REC];
    logic [63:0]  image [MEM_WORDS];
    xlen_t        exp_pc [$];
    int           redir_q [$];
    xlen_t        tvec_val;
    logic         tvec_set;
    int           bp_start;
    int           bp_end;
    int           out_count;
    int           stall;

    fetch_top #(
        .QUEUE_DEPTH (4),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_DELAY   (2)
    ) dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .br_taken_i    (br_taken_i),
        .jal_i         (jal_i),
        .jalr_i        (jalr_i),
        .trap_i        (trap_i),
        .alu_res_i     (alu_res_i),
        .ex_pc_i       (ex_pc_i),
        .imm_i         (imm_i),
        .rs1_i         (rs1_i),
        .tvec_we_i     (tvec_we_i),
        .tvec_wdata_i  (tvec_wdata_i),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_pc_o      (out_pc_o),
        .out_inst_o    (out_inst_o),
        .redir_cause_o (redir_cause)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic abort_run(input string why);
        $display("at %0t: %s", $time, why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // each instruction word is the seed xor its byte address in the RAM
    task automatic fill_beats(input int first, input int count, input logic [31:0] seed);
        logic [7:0]  idx;
        logic [63:0] beat;
        for (int b = first; b < first + count; b++) begin
            idx  = 8'(b);
            beat = {seed ^ {21'b0, idx, 3'b100}, seed ^ {21'b0, idx, 3'b000}};
            @(negedge clk);
            load_we_i   = 1'b1;
            load_addr_i = idx;
            load_data_i = beat;
            image[idx]  = beat;
        end
        @(negedge clk);
        load_we_i = 1'b0;
    endtask

    // pc bit 2 selects the upper half of the beat
    function automatic inst_t expected_inst(input xlen_t pc);
        logic [63:0] beat;
        beat = image[pc[10:3]];
        return pc[2] ? beat[63:32] : beat[31:0];
    endfunction

    function automatic redirect_cause_t expected_cause(input logic [3:0] flags,
                                                       input xlen_t alu);
        redirect_cause_t cause;
        cause = CAUSE_NONE;
        if (flags[0] || (flags[1] && alu == '0)) begin
            cause = CAUSE_BRANCH;
        end else if (flags[2]) begin
            cause = CAUSE_JALR;
        end else if (flags[3]) begin
            cause = CAUSE_TRAP;
        end
        return cause;
    endfunction

    task automatic clear_pulses();
        jal_i      = 1'b0;
        br_taken_i = 1'b0;
        jalr_i     = 1'b0;
        trap_i     = 1'b0;
        tvec_we_i  = 1'b0;
    endtask

    // ready stays low through the hold so the queue fills up first
    task automatic issue_redirect(input int r);
        logic [3:0] flags;
        flags = pat[r][283:280];
        for (int h = 0; h < int'(pat[r][279:272]); h++) begin
            @(negedge clk);
        end
        jal_i      = flags[0];
        br_taken_i = flags[1];
        jalr_i     = flags[2];
        trap_i     = flags[3];
        ex_pc_i    = pat[r][255:192];
        imm_i      = pat[r][191:128];
        rs1_i      = pat[r][127:64];
        alu_res_i  = pat[r][63:0];
        #1;
        check_value("redirect cause", 64'(redir_cause),
                    64'(expected_cause(flags, pat[r][63:0])));
    endtask

    initial begin
        logic [7:0] op;
        reset_i      = 1'b1;
        alu_res_i    = '0;
        ex_pc_i      = '0;
        imm_i        = '0;
        rs1_i        = '0;
        tvec_wdata_i = '0;
        load_addr_i  = '0;
        load_data_i  = '0;
        load_we_i    = 1'b0;
        out_ready_i  = 1'b0;
        clear_pulses();
        tvec_set  = 1'b0;
        tvec_val  = '0;
        bp_start  = 0;
        bp_end    = 0;
        out_count = 0;
        stall     = 0;
        void'($urandom(32'h9018));

        foreach (pat[i]) begin
            pat[i] = '0;
        end
        $readmemh("test/fetch_patterns.txt", pat);
        if (pat[0][287:280] == 8'h00) begin
            abort_run("pattern file is missing or empty");
        end

        // memory loads run while reset is held
        for (int i = 0; i < N_REC; i++) begin
            op = pat[i][287:280];
            if (op == 8'h01) begin
                fill_beats(int'(pat[i][255:192]), int'(pat[i][191:128]), pat[i][95:64]);
            end else if (op == 8'h02) begin
                tvec_set = 1'b1;
                tvec_val = pat[i][255:192];
            end else if (op == 8'h03) begin
                bp_start = int'(pat[i][271:256]);
                bp_end   = int'(pat[i][255:192]);
            end else if (op == 8'h04) begin
                for (int k = 0; k < int'(pat[i][191:128]); k++) begin
                    exp_pc.push_back(pat[i][255:192] + xlen_t'(4 * k));
                end
            end else if (op[7:4] == 4'h1) begin
                redir_q.push_back(i);
            end
        end

        repeat (8) @(negedge clk);
        reset_i      = 1'b0;
        tvec_we_i    = tvec_set;
        tvec_wdata_i = tvec_val;

        while (out_count < exp_pc.size()) begin
            @(negedge clk);
            clear_pulses();
            if (redir_q.size() > 0 && int'(pat[redir_q[0]][271:256]) == out_count) begin
                out_ready_i = 1'b0;
                issue_redirect(redir_q.pop_front());
                stall = 0;
            end else begin
                if (out_count >= bp_start && out_count < bp_end) begin
                    out_ready_i = (($urandom % 3) == 0);
                end else begin
                    out_ready_i = 1'b1;
                end
                // item on the outputs now is taken at the next rising edge
                if (out_valid_o && out_ready_i) begin
                    check_value("pc", out_pc_o, exp_pc[out_count]);
                    check_value("instruction", 64'(out_inst_o),
                                64'(expected_inst(exp_pc[out_count])));
                    out_count++;
                    stall = 0;
                end else begin
                    stall++;
                    if (stall > STALL_LIMIT) begin
                        abort_run("no output was accepted for too long");
                    end
                end
            end
        end

        @(negedge clk);
        out_ready_i = 1'b0;
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256,
    parameter int MEM_DELAY   = 2
) (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    input  wire logic                         br_taken_i,
    input  wire logic                         jal_i,
    input  wire logic                         jalr_i,
    input  wire logic                         trap_i,
    input  wire rv_fetch_pkg::xlen_t          alu_res_i,
    input  wire rv_fetch_pkg::xlen_t          ex_pc_i,
    input  wire rv_fetch_pkg::xlen_t          imm_i,
    input  wire rv_fetch_pkg::xlen_t          rs1_i,
    input  wire logic                         tvec_we_i,
    input  wire rv_fetch_pkg::xlen_t          tvec_wdata_i,
    input  wire logic                         load_we_i,
    input  wire logic [$clog2(MEM_WORDS)-1:0] load_addr_i,
    input  wire rd_bus_pkg::bus_beat_t        load_data_i,
    output logic                              out_valid_o,
    input  wire logic                         out_ready_i,
    output rv_fetch_pkg::xlen_t               out_pc_o,
    output rv_fetch_pkg::inst_t               out_inst_o,
    output rv_fetch_pkg::redirect_cause_t     redir_cause_o
);
    import rv_fetch_pkg::*;
    import rd_bus_pkg::*;

    xlen_t       trap_vec;
    logic        redir_valid;
    xlen_t       redir_pc;
    logic        queue_flush;
    logic        rd_addr_valid;
    logic        rd_addr_ready;
    bus_addr_t   rd_addr;
    rd_size_t    rd_size;
    logic        rd_data_valid;
    logic        rd_data_ready;
    bus_beat_t   rd_data;
    logic        push_valid;
    logic        push_ready;
    fetch_item_t push_item;

    trap_vector_regs u_tvec (
        .clk          (clk),
        .reset_i      (reset_i),
        .tvec_we_i    (tvec_we_i),
        .tvec_wdata_i (tvec_wdata_i),
        .trap_vec_o   (trap_vec)
    );

    fetch_redirect u_redirect (
        .clk           (clk),
        .reset_i       (reset_i),
        .jal_i         (jal_i),
        .br_taken_i    (br_taken_i),
        .alu_res_i     (alu_res_i),
        .jalr_i        (jalr_i),
        .trap_i        (trap_i),
        .ex_pc_i       (ex_pc_i),
        .imm_i         (imm_i),
        .rs1_i         (rs1_i),
        .trap_vec_i    (trap_vec),
        .redir_valid_o (redir_valid),
        .redir_pc_o    (redir_pc),
        .redir_cause_o (redir_cause_o)
    );

    fetch_unit u_fetch (
        .clk             (clk),
        .reset_i         (reset_i),
        .redir_valid_i   (redir_valid),
        .redir_pc_i      (redir_pc),
        .rd_addr_ready_i (rd_addr_ready),
        .rd_data_valid_i (rd_data_valid),
        .rd_data_i       (rd_data),
        .push_ready_i    (push_ready),
        .rd_addr_valid_o (rd_addr_valid),
        .rd_addr_o       (rd_addr),
        .rd_size_o       (rd_size),
        .rd_data_ready_o (rd_data_ready),
        .push_valid_o    (push_valid),
        .push_item_o     (push_item),
        .queue_flush_o   (queue_flush)
    );

    // item packs pc above inst, matching the output port pair
    fetch_queue #(
        .payload_t (fetch_item_t),
        .DEPTH     (QUEUE_DEPTH)
    ) u_queue (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (queue_flush),
        .in_valid_i  (push_valid),
        .in_data_i   (push_item),
        .in_ready_o  (push_ready),
        .out_valid_o (out_valid_o),
        .out_data_o  ({out_pc_o, out_inst_o}),
        .out_ready_i (out_ready_i)
    );

    imem_ram #(
        .WORDS (MEM_WORDS),
        .DELAY (MEM_DELAY)
    ) u_imem (
        .clk             (clk),
        .reset_i         (reset_i),
        .load_we_i       (load_we_i),
        .load_addr_i     (load_addr_i),
        .load_data_i     (load_data_i),
        .rd_addr_valid_i (rd_addr_valid),
        .rd_addr_i       (rd_addr),
        .rd_size_i       (rd_size),
        .rd_data_ready_i (rd_data_ready),
        .rd_addr_ready_o (rd_addr_ready),
        .rd_data_valid_o (rd_data_valid),
        .rd_data_o       (rd_data)
    );

endmodule

`default_nettype wire

/* rtl/imem_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module imem_ram #(
    parameter int WORDS = 256,
    parameter int DELAY = 2
) (
    input  wire logic                      clk,
    input  wire logic                      reset_i,
    input  wire logic                      load_we_i,
    input  wire logic [$clog2(WORDS)-1:0]  load_addr_i,
    input  wire rd_bus_pkg::bus_beat_t     load_data_i,
    input  wire logic                      rd_addr_valid_i,
    input  wire rd_bus_pkg::bus_addr_t     rd_addr_i,
    input  wire rd_bus_pkg::rd_size_t      rd_size_i,
    input  wire logic                      rd_data_ready_i,
    output logic                           rd_addr_ready_o,
    output logic                           rd_data_valid_o,
    output rd_bus_pkg::bus_beat_t          rd_data_o
);
    import rd_bus_pkg::*;

    localparam int IDX_W = $clog2(WORDS);
    localparam int CNT_W = $clog2(DELAY + 1);

    bus_beat_t        mem_q [WORDS];
    logic             busy_q;
    logic [CNT_W-1:0] wait_q;
    logic [IDX_W-1:0] rd_idx;
    logic             addr_xfer;
    logic             data_xfer;

    // upper address bits are ignored, RAM aliases across the space
    assign rd_idx = rd_addr_i[BEAT_OFFSET +: IDX_W];

    assign rd_addr_ready_o = !busy_q;
    assign rd_data_valid_o = busy_q && (wait_q == '0);

    assign addr_xfer = rd_addr_valid_i && rd_addr_ready_o;
    assign data_xfer = rd_data_valid_o && rd_data_ready_i;

    // read happens at address accept, needs DELAY of at least one
    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem_q[load_addr_i] <= load_data_i;
        end
        if (addr_xfer) begin
            rd_data_o <= mem_q[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            wait_q <= '0;
        end else if (addr_xfer) begin
            busy_q <= 1'b1;
            wait_q <= CNT_W'(DELAY);
        end else if (data_xfer) begin
            busy_q <= 1'b0;
        end else if (busy_q && wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
        end
    end

    a_word_size: assert property (
        @(posedge clk) disable iff (reset_i)
        addr_xfer |-> rd_size_i == RD_SIZE_WORD
    );

endmodule

`default_nettype wire

/* rtl/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     flush_i,
    input  wire logic     in_valid_i,
    input  wire payload_t in_data_i,
    output logic          in_ready_o,
    output logic          out_valid_o,
    output payload_t      out_data_o,
    input  wire logic     out_ready_i
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0);
    // head comes straight from the storage registers
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

    // flush wins over a push or pop in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (reset_i)
        $past(in_valid_i && in_ready_o) |-> $past(count_q) < CNT_W'(DEPTH)
    );

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  redir_valid_i,
    input  wire rv_fetch_pkg::xlen_t   redir_pc_i,
    input  wire logic                  rd_addr_ready_i,
    input  wire logic                  rd_data_valid_i,
    input  wire rd_bus_pkg::bus_beat_t rd_data_i,
    input  wire logic                  push_ready_i,
    output logic                       rd_addr_valid_o,
    output rd_bus_pkg::bus_addr_t      rd_addr_o,
    output rd_bus_pkg::rd_size_t       rd_size_o,
    output logic                       rd_data_ready_o,
    output logic                       push_valid_o,
    output rv_fetch_pkg::fetch_item_t  push_item_o,
    output logic                       queue_flush_o
);
    import rv_fetch_pkg::*;
    import rd_bus_pkg::*;

    xlen_t pc_q;
    // address accepted, beat not yet back
    logic  busy_q;
    logic  stale_q;
    logic  addr_xfer;
    logic  data_xfer;
    logic  keep_beat;
    logic  start_req;
    inst_t beat_inst;

    assign addr_xfer = rd_addr_valid_o && rd_addr_ready_i;
    assign data_xfer = rd_data_valid_i && rd_data_ready_o;

    // beat belongs to the current pc and no redirect cancels it
    assign keep_beat = data_xfer && !stale_q && !redir_valid_i;

    // wait one cycle after a redirect so the new pc is used
    assign start_req = !rd_addr_valid_o && !busy_q && !redir_valid_i;

    assign rd_size_o     = RD_SIZE_WORD;
    assign queue_flush_o = redir_valid_i;

    // stale beats always drain, live ones need a free push slot
    assign rd_data_ready_o = busy_q && (stale_q || !push_valid_o || push_ready_i);

    // pc bit 2 picks the half of the beat
    assign beat_inst = pc_q[BEAT_OFFSET-1] ? rd_data_i[2*ILEN-1:ILEN] : rd_data_i[ILEN-1:0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (redir_valid_i) begin
            pc_q <= redir_pc_i;
        end else if (keep_beat) begin
            pc_q <= pc_q + xlen_t'(INST_BYTES);
        end
    end

    // request handshake, one in flight at a time
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_addr_valid_o <= 1'b0;
            busy_q          <= 1'b0;
        end else begin
            if (start_req) begin
                rd_addr_valid_o <= 1'b1;
            end else if (addr_xfer) begin
                rd_addr_valid_o <= 1'b0;
            end
            if (addr_xfer) begin
                busy_q <= 1'b1;
            end else if (data_xfer) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            rd_addr_o <= pc_q & ~bus_addr_t'(BEAT_BYTES - 1);
        end
    end

    // a request still on the bus when the pc jumps comes back stale
    always_ff @(posedge clk) begin
        if (reset_i) begin
            stale_q <= 1'b0;
        end else if (redir_valid_i && (rd_addr_valid_o || (busy_q && !data_xfer))) begin
            stale_q <= 1'b1;
        end else if (data_xfer) begin
            stale_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            push_valid_o <= 1'b0;
        end else if (redir_valid_i) begin
            push_valid_o <= 1'b0;
        end else if (keep_beat) begin
            push_valid_o <= 1'b1;
        end else if (push_ready_i) begin
            push_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (keep_beat) begin
            push_item_o.pc   <= pc_q;
            push_item_o.inst <= beat_inst;
        end
    end

    a_single_outstanding: assert property (
        @(posedge clk) disable iff (reset_i)
        $rose(rd_addr_valid_o) |-> !busy_q && !$past(busy_q)
    );

endmodule

`default_nettype wire

/* rtl/trap_vector_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_vector_regs (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                tvec_we_i,
    input  wire rv_fetch_pkg::xlen_t tvec_wdata_i,
    output rv_fetch_pkg::xlen_t      trap_vec_o
);
    import rv_fetch_pkg::*;

    xlen_t tvec_aligned;

    // direct mode only, mode bits read as zero
    assign tvec_aligned = {tvec_wdata_i[XLEN-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            trap_vec_o <= RESET_PC;
        end else if (tvec_we_i) begin
            trap_vec_o <= tvec_aligned;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_redirect.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_redirect (
    input  wire logic                     clk,
    input  wire logic                     reset_i,
    input  wire logic                     jal_i,
    input  wire logic                     br_taken_i,
    input  wire rv_fetch_pkg::xlen_t      alu_res_i,
    input  wire logic                     jalr_i,
    input  wire logic                     trap_i,
    input  wire rv_fetch_pkg::xlen_t      ex_pc_i,
    input  wire rv_fetch_pkg::xlen_t      imm_i,
    input  wire rv_fetch_pkg::xlen_t      rs1_i,
    input  wire rv_fetch_pkg::xlen_t      trap_vec_i,
    output logic                          redir_valid_o,
    output rv_fetch_pkg::xlen_t           redir_pc_o,
    output rv_fetch_pkg::redirect_cause_t redir_cause_o
);
    import rv_fetch_pkg::*;

    logic  branch_hit;
    xlen_t pc_rel_target;
    xlen_t reg_rel_target;

    // branch compare is done by the alu, zero means taken
    assign branch_hit     = br_taken_i && (alu_res_i == '0);
    assign pc_rel_target  = ex_pc_i + imm_i;
    assign reg_rel_target = rs1_i + imm_i;

    assign redir_valid_o = jal_i || branch_hit || jalr_i || trap_i;

    // fixed priority, pc-relative first
    always_comb begin
        redir_cause_o = CAUSE_NONE;
        redir_pc_o    = pc_rel_target;
        if (jal_i || branch_hit) begin
            redir_cause_o = CAUSE_BRANCH;
            redir_pc_o    = pc_rel_target;
        end else if (jalr_i) begin
            redir_cause_o = CAUSE_JALR;
            redir_pc_o    = {reg_rel_target[XLEN-1:1], 1'b0};
        end else if (trap_i) begin
            redir_cause_o = CAUSE_TRAP;
            redir_pc_o    = trap_vec_i;
        end
    end

    // valid and cause come from separate decodes
    a_cause_matches_valid: assert property (
        @(posedge clk) disable iff (reset_i)
        (redir_cause_o == CAUSE_NONE) == !redir_valid_o
    );

endmodule

`default_nettype wire

/* rtl/rd_bus_pkg.sv */
`default_nettype none

package rd_bus_pkg;

    localparam int BUS_AW = 64;
    localparam int BUS_DW = 64;

    localparam int BEAT_BYTES  = BUS_DW / 8;
    // address bits below the beat boundary
    localparam int BEAT_OFFSET = $clog2(BEAT_BYTES);

    typedef logic [BUS_AW-1:0] bus_addr_t;
    typedef logic [BUS_DW-1:0] bus_beat_t;

    // size is log2 of the byte count, as on AXI
    typedef logic [2:0] rd_size_t;

    localparam rd_size_t RD_SIZE_WORD = rd_size_t'(BEAT_OFFSET);

endpackage

`default_nettype wire

/* rtl/rv_fetch_pkg.sv */
`default_nettype none

package rv_fetch_pkg;

    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // no compressed support, every instruction is a full word
    localparam int INST_BYTES = ILEN / 8;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;

    localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

    // jal and taken branches share one cause
    typedef enum logic [1:0] {
        CAUSE_NONE   = 2'd0,
        CAUSE_BRANCH = 2'd1,
        CAUSE_JALR   = 2'd2,
        CAUSE_TRAP   = 2'd3
    } redirect_cause_t;

    typedef struct packed {
        xlen_t pc;
        inst_t inst;
    } fetch_item_t;

endpackage

`default_nettype wire
